/* verilog/linear_macros.svh */
`ifndef LINEAR_MACROS_SVH
`define LINEAR_MACROS_SVH

// Signed element format with LIN_FRAC fraction bits
`define LIN_DATA_W 8
`define LIN_FRAC 3

// Input row geometry
`define LIN_IN_SIZE 8
`define LIN_IN_PAR 2
`define LIN_IN_DEPTH (`LIN_IN_SIZE / `LIN_IN_PAR)

// Output geometry
`define LIN_OUT_SIZE 4
`define LIN_OUT_PAR 2
`define LIN_OUT_DEPTH (`LIN_OUT_SIZE / `LIN_OUT_PAR)
`define LIN_W_BEATS (`LIN_OUT_DEPTH * `LIN_IN_DEPTH)
`define LIN_ROWS 4

// Full product plus one tree carry plus two depth carries
`define LIN_ACC_W 19
`define LIN_SUM_W (`LIN_ACC_W + 1)

`endif

/* verilog/linear_pkg.sv */
`include "linear_macros.svh"

package linear_pkg;

  // Fixed-point element shared by data, weights, bias and results
  typedef logic signed [`LIN_DATA_W-1:0] elem_t;

  typedef struct packed {
    elem_t [`LIN_IN_PAR-1:0] elem;
  } data_beat_t;

  // One weight row lines up element for element with a data beat
  typedef struct packed {
    elem_t [`LIN_IN_PAR-1:0] elem;
  } weight_row_t;

  // Row i feeds output lane i
  typedef struct packed {
    weight_row_t [`LIN_OUT_PAR-1:0] row;
  } weight_beat_t;

  typedef struct packed {
    elem_t [`LIN_OUT_PAR-1:0] elem;
  } bias_beat_t;

  typedef struct packed {
    elem_t [`LIN_OUT_PAR-1:0] elem;
  } out_beat_t;

  // Products and sums carry 2*LIN_FRAC fraction bits
  typedef logic signed [`LIN_ACC_W-1:0] acc_t;
  typedef logic signed [`LIN_SUM_W-1:0] sum_t;

  typedef enum logic {
    BUF_FILL,
    BUF_REPLAY
  } buf_state_e;

endpackage

/* verilog/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer #(
  parameter int BEAT_W = 16,
  parameter int DEPTH = 4,
  parameter int REPEAT = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [BEAT_W-1:0] in_data,
  input  logic              in_valid,
  output logic              in_ready,
  output logic [BEAT_W-1:0] out_data,
  output logic              out_valid,
  input  logic              out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int REP_W = (REPEAT > 1) ? $clog2(REPEAT) : 1;

  logic [BEAT_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [REP_W-1:0] rep_cnt;
  linear_pkg::buf_state_e state;

  logic in_fire;
  logic out_fire;
  logic last_wr;
  logic last_rd;
  logic last_rep;

  // Input side is open only while filling, output only while replaying
  assign in_ready = (state == linear_pkg::BUF_FILL);
  assign out_valid = (state == linear_pkg::BUF_REPLAY);
  assign out_data = mem[rd_ptr];

  assign in_fire = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;
  assign last_wr = (wr_ptr == PTR_W'(DEPTH - 1));
  assign last_rd = (rd_ptr == PTR_W'(DEPTH - 1));
  assign last_rep = (rep_cnt == REP_W'(REPEAT - 1));

  always_ff @(posedge clk) begin
    if (in_fire) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= linear_pkg::BUF_FILL;
      wr_ptr <= '0;
      rd_ptr <= '0;
      rep_cnt <= '0;
    end else begin
      case (state)
        linear_pkg::BUF_FILL: begin
          if (in_fire) begin
            if (last_wr) begin
              wr_ptr <= '0;
              state <= linear_pkg::BUF_REPLAY;
            end else begin
              wr_ptr <= wr_ptr + 1'b1;
            end
          end
        end
        linear_pkg::BUF_REPLAY: begin
          if (out_fire) begin
            if (last_rd) begin
              rd_ptr <= '0;
              // Whole set sent once more; back to fill after the final pass
              if (last_rep) begin
                rep_cnt <= '0;
                state <= linear_pkg::BUF_FILL;
              end else begin
                rep_cnt <= rep_cnt + 1'b1;
              end
            end else begin
              rd_ptr <= rd_ptr + 1'b1;
            end
          end
        end
        default: begin
          state <= linear_pkg::BUF_FILL;
        end
      endcase
    end
  end

endmodule

/* verilog/fixed_dot_product.sv */
`timescale 1ns/1ps
`include "linear_macros.svh"

module fixed_dot_product (
  input  logic                    clk,
  input  logic                    rst,
  input  linear_pkg::data_beat_t  data,
  input  linear_pkg::weight_row_t weight_row,
  input  logic                    in_valid,
  output logic                    in_ready,
  output linear_pkg::acc_t        dot,
  output logic                    out_valid,
  input  logic                    out_ready
);

  localparam int PROD_W = 2 * `LIN_DATA_W;

  logic signed [PROD_W-1:0] prod [`LIN_IN_PAR];
  linear_pkg::acc_t tree;

  // Products keep full precision before the add tree
  always_comb begin
    tree = '0;
    for (int i = 0; i < `LIN_IN_PAR; i++) begin
      prod[i] = $signed(data.elem[i]) * $signed(weight_row.elem[i]);
      tree = tree + linear_pkg::acc_t'(prod[i]);
    end
  end

  // Single output register, refilled when empty or being drained
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      dot <= tree;
    end
  end

endmodule

/* verilog/fixed_accumulator.sv */
`timescale 1ns/1ps
`include "linear_macros.svh"

module fixed_accumulator (
  input  logic             clk,
  input  logic             rst,
  input  linear_pkg::acc_t dot,
  input  logic             in_valid,
  output logic             in_ready,
  output linear_pkg::acc_t acc,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int CNT_W = (`LIN_IN_DEPTH > 1) ? $clog2(`LIN_IN_DEPTH) : 1;

  logic [CNT_W-1:0] cnt;
  logic in_fire;
  logic out_fire;
  logic last_beat;

  // Input stalls while a finished sum waits to be taken
  assign in_ready = !out_valid;
  assign in_fire = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;
  assign last_beat = (cnt == CNT_W'(`LIN_IN_DEPTH - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
      cnt <= '0;
      out_valid <= 1'b0;
    end else begin
      if (out_fire) begin
        // Start the next output from zero
        acc <= '0;
        out_valid <= 1'b0;
      end else if (in_fire) begin
        acc <= acc + dot;
        if (last_beat) begin
          cnt <= '0;
          out_valid <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* verilog/linear_result.sv */
`timescale 1ns/1ps
`include "linear_macros.svh"

module linear_result (
  input  logic                                  clk,
  input  logic                                  rst,
  input  linear_pkg::acc_t [`LIN_OUT_PAR-1:0]   acc,
  input  logic                                  acc_valid,
  output logic                                  acc_ready,
  input  linear_pkg::bias_beat_t                bias,
  input  logic                                  bias_valid,
  output logic                                  bias_ready,
  output linear_pkg::out_beat_t                 data_out,
  output logic                                  data_out_valid,
  input  logic                                  data_out_ready
);

  // Half an output LSB at 2*LIN_FRAC fraction bits
  localparam linear_pkg::sum_t HALF = linear_pkg::sum_t'(1) <<< (`LIN_FRAC - 1);
  localparam linear_pkg::sum_t OUT_MAX = linear_pkg::sum_t'((1 << (`LIN_DATA_W - 1)) - 1);
  localparam linear_pkg::sum_t OUT_MIN = linear_pkg::sum_t'(-(1 << (`LIN_DATA_W - 1)));

  logic load;
  logic join_valid;
  linear_pkg::out_beat_t next_beat;

  // Join accumulators with one bias beat, gated by room in the output register
  assign load = !data_out_valid || data_out_ready;
  assign join_valid = acc_valid && bias_valid;
  assign acc_ready = bias_valid && load;
  assign bias_ready = acc_valid && load;

  always_comb begin
    linear_pkg::sum_t aligned;
    linear_pkg::sum_t total;
    linear_pkg::sum_t rounded;
    next_beat = '0;
    for (int i = 0; i < `LIN_OUT_PAR; i++) begin
      // Bias moves up to the product fraction
      aligned = linear_pkg::sum_t'($signed(bias.elem[i])) <<< `LIN_FRAC;
      total = linear_pkg::sum_t'(acc[i]) + aligned;
      // Round half up, then drop the extra fraction bits
      rounded = (total + HALF) >>> `LIN_FRAC;
      if (rounded > OUT_MAX) begin
        next_beat.elem[i] = linear_pkg::elem_t'(OUT_MAX);
      end else if (rounded < OUT_MIN) begin
        next_beat.elem[i] = linear_pkg::elem_t'(OUT_MIN);
      end else begin
        next_beat.elem[i] = linear_pkg::elem_t'(rounded);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else if (load) begin
      data_out_valid <= join_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (join_valid && load) begin
      data_out <= next_beat;
    end
  end

endmodule

/* verilog/fixed_linear_top.sv */
`timescale 1ns/1ps
`include "linear_macros.svh"

module fixed_linear_top (
  input  logic                     clk,
  input  logic                     rst,
  input  linear_pkg::data_beat_t   data_in,
  input  logic                     data_in_valid,
  output logic                     data_in_ready,
  input  linear_pkg::weight_beat_t weight,
  input  logic                     weight_valid,
  output logic                     weight_ready,
  input  linear_pkg::bias_beat_t   bias,
  input  logic                     bias_valid,
  output logic                     bias_ready,
  output linear_pkg::out_beat_t    data_out,
  output logic                     data_out_valid,
  input  logic                     data_out_ready
);

  linear_pkg::data_beat_t buf_data;
  logic buf_data_valid;
  logic buf_data_ready;
  linear_pkg::weight_beat_t buf_weight;
  logic buf_weight_valid;
  logic buf_weight_ready;
  linear_pkg::bias_beat_t buf_bias;
  logic buf_bias_valid;
  logic buf_bias_ready;

  logic lane_valid;
  logic [`LIN_OUT_PAR-1:0] lane_ready;
  linear_pkg::acc_t [`LIN_OUT_PAR-1:0] lane_acc;
  logic [`LIN_OUT_PAR-1:0] acc_valid;
  logic acc_ready;

  // Row replays once per output block
  input_buffer #(
    .BEAT_W ($bits(linear_pkg::data_beat_t)),
    .DEPTH  (`LIN_IN_DEPTH),
    .REPEAT (`LIN_OUT_DEPTH)
  ) data_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_data   (data_in),
    .in_valid  (data_in_valid),
    .in_ready  (data_in_ready),
    .out_data  (buf_data),
    .out_valid (buf_data_valid),
    .out_ready (buf_data_ready)
  );

  // Weights and bias replay once per input row
  input_buffer #(
    .BEAT_W ($bits(linear_pkg::weight_beat_t)),
    .DEPTH  (`LIN_W_BEATS),
    .REPEAT (`LIN_ROWS)
  ) weight_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_data   (weight),
    .in_valid  (weight_valid),
    .in_ready  (weight_ready),
    .out_data  (buf_weight),
    .out_valid (buf_weight_valid),
    .out_ready (buf_weight_ready)
  );

  input_buffer #(
    .BEAT_W ($bits(linear_pkg::bias_beat_t)),
    .DEPTH  (`LIN_OUT_DEPTH),
    .REPEAT (`LIN_ROWS)
  ) bias_buffer (
    .clk       (clk),
    .rst       (rst),
    .in_data   (bias),
    .in_valid  (bias_valid),
    .in_ready  (bias_ready),
    .out_data  (buf_bias),
    .out_valid (buf_bias_valid),
    .out_ready (buf_bias_ready)
  );

  // Data and weight advance together; lanes run in lockstep so lane 0 speaks for all
  assign lane_valid = buf_data_valid && buf_weight_valid;
  assign buf_data_ready = buf_weight_valid && lane_ready[0];
  assign buf_weight_ready = buf_data_valid && lane_ready[0];

  for (genvar i = 0; i < `LIN_OUT_PAR; i++) begin : g_lane
    linear_pkg::acc_t dot;
    logic dot_valid;
    logic dot_ready;

    fixed_dot_product dot_product_inst (
      .clk        (clk),
      .rst        (rst),
      .data       (buf_data),
      .weight_row (buf_weight.row[i]),
      .in_valid   (lane_valid),
      .in_ready   (lane_ready[i]),
      .dot        (dot),
      .out_valid  (dot_valid),
      .out_ready  (dot_ready)
    );

    fixed_accumulator accumulator_inst (
      .clk       (clk),
      .rst       (rst),
      .dot       (dot),
      .in_valid  (dot_valid),
      .in_ready  (dot_ready),
      .acc       (lane_acc[i]),
      .out_valid (acc_valid[i]),
      .out_ready (acc_ready)
    );
  end

  linear_result result_inst (
    .clk            (clk),
    .rst            (rst),
    .acc            (lane_acc),
    .acc_valid      (&acc_valid),
    .acc_ready      (acc_ready),
    .bias           (buf_bias),
    .bias_valid     (buf_bias_valid),
    .bias_ready     (buf_bias_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

/* dv/linear_ref_model.svh */
`ifndef LINEAR_REF_MODEL_SVH
`define LINEAR_REF_MODEL_SVH

// Layer contents as raw fixed-point integers
int model_w [`LIN_OUT_SIZE][`LIN_IN_SIZE];
int model_b [`LIN_OUT_SIZE];
int model_x [`LIN_IN_SIZE];

localparam int OUT_HI = (1 << (`LIN_DATA_W - 1)) - 1;
localparam int OUT_LO = -(1 << (`LIN_DATA_W - 1));

// Sum carries 2*LIN_FRAC fraction bits; floor of (sum + half) / scale
function automatic int round_sat(int total);
  int scale;
  int num;
  int r;
  scale = 1 << `LIN_FRAC;
  num = total + scale / 2;
  r = num / scale;
  // Integer divide truncates toward zero, floor needs one step down
  if ((num % scale != 0) && (num < 0)) begin
    r = r - 1;
  end
  if (r > OUT_HI) begin
    r = OUT_HI;
  end else if (r < OUT_LO) begin
    r = OUT_LO;
  end
  return r;
endfunction

// Output block j of the current row
function automatic linear_pkg::out_beat_t expected_beat(int j);
  linear_pkg::out_beat_t beat;
  int o;
  int total;
  beat = '0;
  for (int i = 0; i < `LIN_OUT_PAR; i++) begin
    o = j * `LIN_OUT_PAR + i;
    total = model_b[o] * (1 << `LIN_FRAC);
    for (int n = 0; n < `LIN_IN_SIZE; n++) begin
      total += model_x[n] * model_w[o][n];
    end
    beat.elem[i] = linear_pkg::elem_t'(round_sat(total));
  end
  return beat;
endfunction

`endif

/* dv/tb_fixed_linear.sv */
`timescale 1ns/1ps
`include "linear_macros.svh"

module tb_fixed_linear;

  localparam int MODE_RANDOM = 0;
  localparam int MODE_SATURATE = 1;
  localparam int MODE_TIES = 2;
  localparam int LAYERS = 5;
  localparam int SENT = LAYERS * (`LIN_W_BEATS + `LIN_OUT_DEPTH + `LIN_ROWS * `LIN_IN_DEPTH);
  localparam int EXPECTED = LAYERS * `LIN_ROWS * `LIN_OUT_DEPTH;
  localparam int CYCLE_LIMIT = 4 * (SENT + EXPECTED) + 200;

  logic clk = 1'b0;
  logic rst;
  linear_pkg::data_beat_t data_in;
  logic data_in_valid;
  logic data_in_ready;
  linear_pkg::weight_beat_t weight;
  logic weight_valid;
  logic weight_ready;
  linear_pkg::bias_beat_t bias;
  logic bias_valid;
  logic bias_ready;
  linear_pkg::out_beat_t data_out;
  logic data_out_valid;
  logic data_out_ready;

  linear_pkg::out_beat_t expect_q[$];
  bit random_ready;
  int errors;
  int checks;
  int tests;
  int cycles;

  `include "linear_ref_model.svh"

  fixed_linear_top i_fixed_linear_top (.*);

  always #50 clk = ~clk;

  task automatic check_out(linear_pkg::out_beat_t got, linear_pkg::out_beat_t want);
    checks++;
    for (int i = 0; i < `LIN_OUT_PAR; i++) begin
      if (got.elem[i] !== want.elem[i]) begin
        errors++;
        $display("Fail at %0d ns: lane %0d got %0d expected %0d",
                 $time, i, got.elem[i], want.elem[i]);
      end
    end
  endtask

  task automatic check_flag(logic got, logic want, string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  function automatic int rand_elem();
    logic signed [`LIN_DATA_W-1:0] v;
    v = `LIN_DATA_W'($urandom);
    return int'(v);
  endfunction

  function automatic int pick_weight(int mode, int o, int n);
    if (mode == MODE_SATURATE) begin
      return (o % 2 == 0) ? OUT_HI : OUT_LO;
    end else if (mode == MODE_TIES) begin
      // Times an odd data value this lands on a half-LSB tie
      return (n != 0) ? 0 : ((o % 2 == 0) ? 4 : -4);
    end
    return rand_elem();
  endfunction

  function automatic int pick_data(int mode, int r, int n);
    if (mode == MODE_SATURATE) begin
      return (r % 2 == 0) ? OUT_HI : OUT_LO;
    end else if (mode == MODE_TIES && n == 0) begin
      return (int'(6'($urandom)) | 1) - 32;
    end
    return rand_elem();
  endfunction

  task automatic send_data(linear_pkg::data_beat_t beat);
    logic accepted;
    data_in = beat;
    data_in_valid = 1'b1;
    do begin
      accepted = data_in_ready;
      @(negedge clk);
    end while (!accepted);
    data_in_valid = 1'b0;
  endtask

  task automatic send_weight(linear_pkg::weight_beat_t beat);
    logic accepted;
    weight = beat;
    weight_valid = 1'b1;
    do begin
      accepted = weight_ready;
      @(negedge clk);
    end while (!accepted);
    weight_valid = 1'b0;
  endtask

  task automatic send_bias(linear_pkg::bias_beat_t beat);
    logic accepted;
    bias = beat;
    bias_valid = 1'b1;
    do begin
      accepted = bias_ready;
      @(negedge clk);
    end while (!accepted);
    bias_valid = 1'b0;
  endtask

  task automatic run_layer(string name, int mode);
    linear_pkg::weight_beat_t wb;
    linear_pkg::bias_beat_t bb;
    linear_pkg::data_beat_t db;
    int errors_before;
    errors_before = errors;
    tests++;
    for (int o = 0; o < `LIN_OUT_SIZE; o++) begin
      model_b[o] = (mode == MODE_TIES) ? 0 : rand_elem();
      for (int n = 0; n < `LIN_IN_SIZE; n++) begin
        model_w[o][n] = pick_weight(mode, o, n);
      end
    end
    // Weight beat j*IN_DEPTH+k holds block j against data beat k
    for (int b = 0; b < `LIN_W_BEATS; b++) begin
      for (int i = 0; i < `LIN_OUT_PAR; i++) begin
        for (int e = 0; e < `LIN_IN_PAR; e++) begin
          wb.row[i].elem[e] = linear_pkg::elem_t'(
            model_w[(b / `LIN_IN_DEPTH) * `LIN_OUT_PAR + i][(b % `LIN_IN_DEPTH) * `LIN_IN_PAR + e]);
        end
      end
      send_weight(wb);
    end
    for (int j = 0; j < `LIN_OUT_DEPTH; j++) begin
      for (int i = 0; i < `LIN_OUT_PAR; i++) begin
        bb.elem[i] = linear_pkg::elem_t'(model_b[j * `LIN_OUT_PAR + i]);
      end
      send_bias(bb);
    end
    for (int r = 0; r < `LIN_ROWS; r++) begin
      for (int n = 0; n < `LIN_IN_SIZE; n++) begin
        model_x[n] = pick_data(mode, r, n);
      end
      for (int j = 0; j < `LIN_OUT_DEPTH; j++) begin
        expect_q.push_back(expected_beat(j));
      end
      for (int k = 0; k < `LIN_IN_DEPTH; k++) begin
        for (int e = 0; e < `LIN_IN_PAR; e++) begin
          db.elem[e] = linear_pkg::elem_t'(model_x[k * `LIN_IN_PAR + e]);
        end
        send_data(db);
      end
    end
    while (expect_q.size() != 0) begin
      @(negedge clk);
    end
    // A few idle cycles catch any extra beat
    repeat (4) @(negedge clk);
    $display("Test %s: %0d errors", name, errors - errors_before);
  endtask

  // Ready for the coming edge is set here; a beat seen valid and ready transfers there
  initial begin
    linear_pkg::out_beat_t want;
    data_out_ready = 1'b0;
    forever begin
      @(negedge clk);
      data_out_ready = random_ready ? 1'($urandom) : 1'b1;
      if (!rst && data_out_valid && data_out_ready) begin
        if (expect_q.size() == 0) begin
          errors++;
          $display("Output beat arrived at %0d ns when none was expected", $time);
        end else begin
          want = expect_q.pop_front();
          check_out(data_out, want);
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d output beats still outstanding",
             cycles, expect_q.size());
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst = 1'b1;
    data_in = '0;
    data_in_valid = 1'b0;
    weight = '0;
    weight_valid = 1'b0;
    bias = '0;
    bias_valid = 1'b0;
    void'($urandom(64));
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    tests++;
    repeat (2) @(negedge clk);
    check_flag(data_out_valid, 1'b0, "data_out_valid");
    check_flag(data_in_ready, 1'b1, "data_in_ready");
    check_flag(weight_ready, 1'b1, "weight_ready");
    check_flag(bias_ready, 1'b1, "bias_ready");
    $display("Test reset state: %0d errors", errors);
    run_layer("single layer", MODE_RANDOM);
    run_layer("second layer", MODE_RANDOM);
    random_ready = 1'b1;
    run_layer("output back-pressure", MODE_RANDOM);
    random_ready = 1'b0;
    run_layer("saturation", MODE_SATURATE);
    run_layer("rounding ties", MODE_TIES);
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verilog
+incdir+dv
verilog/linear_pkg.sv
verilog/input_buffer.sv
verilog/fixed_dot_product.sv
verilog/fixed_accumulator.sv
verilog/linear_result.sv
verilog/fixed_linear_top.sv
dv/tb_fixed_linear.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f verilog.f --top-module tb_fixed_linear
./obj_dir/Vtb_fixed_linear > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
